/* Makefile */
# Verilator build and run for the two-lane word buffer
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= par_codec_tb
FILELIST  ?= par_codec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --assert --timescale 1ns/1ps -Wno-fatal

FAIL_MSG := ERRORS FOUND
PASS_MSG := NO ERRORS

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, an aborted run lacks the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not finish cleanly"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* par_codec.f */
+incdir+source
source/par_codec_pkg.sv
source/lane_buffer.sv
source/lane_dispatch.sv
source/lane_merge.sv
source/par_codec_top.sv
sim/par_codec_assert.sv
sim/par_codec_tb.sv

/* sim/par_codec_assert.sv */
// checks on par_codec_top; the overflow check is off while overflow_check_on is low
`default_nettype none
`timescale 1ns/1ps

module par_codec_assert (
    input logic clk,
    input logic reset,
    input logic in_credit,
    input logic out_valid,
    input logic overflow,
    input logic pop0,
    input logic pop1
);
    // cleared around a deliberate push beyond the credit pool
    logic overflow_check_on = 1'b1;

    no_overflow: assert property (@(posedge clk)
        disable iff (reset || !overflow_check_on) !overflow)
        else $error("overflow set while the sender kept to its credits");

    // upstream credit comes back one cycle after each pop
    credit_after_pop: assert property (@(posedge clk)
        disable iff (reset) in_credit |-> $past(pop0 || pop1))
        else $error("in_credit pulse without a pop in the previous cycle");

    valid_low_in_reset: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid high during or right after reset");

    // only the current lane may be read
    pops_exclusive: assert property (@(posedge clk)
        disable iff (reset) !(pop0 && pop1))
        else $error("both lanes popped in the same cycle");

endmodule

bind par_codec_top par_codec_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .overflow  (overflow),
    .pop0      (pop0),
    .pop1      (pop1)
);

`default_nettype wire

/* sim/par_codec_tb.sv */
// self-checking testbench; needs source/ on the include path and runs from a fixed LCG seed
`default_nettype none
`timescale 1ns/1ps

`include "par_codec_consts.svh"

module par_codec_tb;
    import par_codec_pkg::*;

    localparam int POOL            = 2 * `PC_DEPTH;
    localparam int LIMIT           = 2000;
    localparam int WATCHDOG_CYCLES = 100000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    word_t       in_data;
    logic        in_credit;
    logic        out_valid;
    word_t       out_data;
    logic        out_credit;
    logic        overflow;

    logic [31:0] rng = 32'd76617;
    // words sent but not yet seen at the output in send order
    word_t       sent_q[$];
    int          send_credits = POOL;
    int          owed_credits = 0;
    int          in_credit_total = 0;
    int          words_out = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_failed = 0;
    int          test_num = 0;

    par_codec_top u_par_codec_top (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit),
        .overflow   (overflow)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // words leave unchanged and in input order
    function automatic word_t expected_word();
        return sent_q.pop_front();
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    // all driving and polling happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_inputs(input bit send, input bit give_credit);
        in_valid   = send;
        out_credit = give_credit;
        if (send) begin
            rng = lcg_next(rng);
            in_data = word_t'(rng >> 8);
            sent_q.push_back(in_data);
        end
    endtask

    task automatic wait_out_words(input int target, input bit give_credits);
        int cycles;
        cycles = 0;
        while (words_out < target && cycles < LIMIT) begin
            next_cycle();
            drive_inputs(1'b0, give_credits && owed_credits > 0 && words_out < target);
            cycles++;
        end
        if (words_out < target) begin
            report_error($sformatf("timeout, output word %0d never came", target));
        end
    endtask

    task automatic return_credits();
        int cycles;
        cycles = 0;
        while (owed_credits > 0 && cycles < LIMIT) begin
            drive_inputs(1'b0, 1'b1);
            next_cycle();
            cycles++;
        end
        drive_inputs(1'b0, 1'b0);
        if (owed_credits > 0) begin
            report_error("timeout, receiver credits were never all returned");
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        check_value("pending words", 32'd0, 32'(sent_q.size()));
        if (error_count == test_errors) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // sender and receiver credit models
    always @(posedge clk) begin
        if (reset) begin
            send_credits = POOL;
            owed_credits = 0;
        end else begin
            send_credits = send_credits + int'(in_credit) - int'(in_valid);
            owed_credits = owed_credits + int'(out_valid) - int'(out_credit);
            in_credit_total = in_credit_total + int'(in_credit);
        end
    end

    // compare every delivered word with the reference
    always @(posedge clk) begin
        if (!reset && out_valid) begin
            if (sent_q.size() == 0) begin
                report_error("word on the output while no word was pending");
            end else begin
                check_value("out_data", 32'(expected_word()), 32'(out_data));
            end
            words_out++;
        end
    end

    initial begin
        int i;
        int k;
        int start_out;
        int start_credit;
        int sent;
        int run_left;
        int cycles;
        bit sending;
        bit send_now;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        repeat (10) next_cycle();
        reset = 1'b0;

        for (i = 0; i < 20; i++) begin
            next_cycle();
            check_value("out_valid", 32'd0, 32'(out_valid));
            check_value("in_credit", 32'd0, 32'(in_credit));
            check_value("overflow", 32'd0, 32'(overflow));
        end
        end_test("reset state");

        // single words with random gaps
        start_out = words_out;
        start_credit = in_credit_total;
        for (i = 0; i < 12; i++) begin
            next_cycle();
            drive_inputs(send_credits > 0, owed_credits > 0);
            rng = lcg_next(rng);
            k = 2 + int'(rng[31:30]);
            repeat (k) begin
                next_cycle();
                drive_inputs(1'b0, owed_credits > 0);
            end
        end
        wait_out_words(start_out + 12, 1'b1);
        return_credits();
        check_value("in_credit pulses", 32'd12, 32'(in_credit_total - start_credit));
        end_test("ordered passthrough");

        // full pool with the receiver holding its credits
        start_out = words_out;
        check_value("send_credits", 32'(POOL), 32'(send_credits));
        for (i = 0; i < POOL; i++) begin
            next_cycle();
            drive_inputs(send_credits > 0, 1'b0);
        end
        next_cycle();
        drive_inputs(1'b0, 1'b0);
        wait_out_words(start_out + `PC_OUT_CREDITS, 1'b0);
        repeat (20) next_cycle();
        check_value("words_out", 32'(start_out + `PC_OUT_CREDITS), 32'(words_out));
        for (k = `PC_OUT_CREDITS + 1; k <= POOL; k++) begin
            next_cycle();
            drive_inputs(1'b0, 1'b1);
            wait_out_words(start_out + k, 1'b0);
            repeat (4) next_cycle();
            check_value("words_out", 32'(start_out + k), 32'(words_out));
        end
        return_credits();
        end_test("back-pressure fill");

        // bursts and gaps of random length with random credit returns
        start_out = words_out;
        start_credit = in_credit_total;
        sent = 0;
        run_left = 0;
        sending = 1'b0;
        cycles = 0;
        while (sent < 200 && cycles < 20 * LIMIT) begin
            next_cycle();
            if (run_left == 0) begin
                rng = lcg_next(rng);
                sending = rng[31];
                run_left = 1 + int'(rng[30:28]);
            end
            run_left--;
            rng = lcg_next(rng);
            send_now = sending && send_credits > 0;
            drive_inputs(send_now, owed_credits > 0 && rng[31]);
            if (send_now) begin
                sent++;
            end
            cycles++;
        end
        if (sent < 200) begin
            report_error("timeout, sender could not place 200 words");
        end
        wait_out_words(start_out + 200, 1'b1);
        return_credits();
        check_value("in_credit pulses", 32'd200, 32'(in_credit_total - start_credit));
        check_value("overflow", 32'd0, 32'(overflow));
        end_test("random traffic");

        // fill both lanes and then push one word past the pool
        u_par_codec_top.u_assert.overflow_check_on = 1'b0;
        start_credit = in_credit_total;
        cycles = 0;
        while (!(send_credits == 0 && in_credit_total - start_credit >= `PC_OUT_CREDITS)
               && cycles < LIMIT) begin
            next_cycle();
            drive_inputs(send_credits > 0, 1'b0);
            cycles++;
        end
        if (cycles >= LIMIT) begin
            report_error("timeout, input credit pool never drained");
        end
        next_cycle();
        in_valid = 1'b1;
        in_data  = '1;
        next_cycle();
        in_valid = 1'b0;
        cycles = 0;
        while (!overflow && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        if (!overflow) begin
            report_error("timeout, overflow never rose");
        end
        for (i = 0; i < 10; i++) begin
            next_cycle();
            check_value("overflow", 32'd1, 32'(overflow));
        end
        reset = 1'b1;
        repeat (10) next_cycle();
        reset = 1'b0;
        check_value("overflow", 32'd0, 32'(overflow));
        sent_q.delete();
        u_par_codec_top.u_assert.overflow_check_on = 1'b1;
        end_test("overflow detection");

        $display("summary: %0d tests, %0d failed, %0d errors",
                 test_num, tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* source/lane_buffer.sv */
// lane FIFO with a registered write stage; a push into a full lane is dropped
`default_nettype none
`timescale 1ns/1ps

`include "par_codec_consts.svh"

module lane_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  par_codec_pkg::word_t push_data,
    input  logic                 pop,
    output par_codec_pkg::word_t rd_data,
    output logic                 not_empty,
    output logic                 full
);
    import par_codec_pkg::*;

    word_t                mem [`PC_DEPTH];

    // write stage between the push and the memory
    logic                 wr_valid;
    word_t                wr_data;

    logic [`PC_PTR_W-1:0] wr_ptr;
    logic [`PC_PTR_W-1:0] rd_ptr;
    logic [`PC_PTR_W:0]   count;

    logic                 wr_en;
    logic                 rd_en;

    // wrap at PC_DEPTH, also for depths that are not a power of two
    function automatic logic [`PC_PTR_W-1:0] next_ptr(input logic [`PC_PTR_W-1:0] ptr);
        return (ptr == `PC_PTR_W'(`PC_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rd_en = pop && not_empty;

    // a full lane still takes a word when a pop frees a slot in the same cycle
    assign wr_en = wr_valid && (!full || rd_en);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= push;
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= push_data;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // occupancy, push and pop together cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // read side is combinational from the read pointer
    assign rd_data   = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (`PC_PTR_W + 1)'(`PC_DEPTH));

endmodule

`default_nettype wire

/* source/lane_dispatch.sv */
// deals words to lane 0 and lane 1 in strict alternation; overflow clears only on reset
`default_nettype none
`timescale 1ns/1ps

module lane_dispatch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  par_codec_pkg::word_t in_data,
    input  logic                 full0,
    input  logic                 full1,
    output logic                 push0,
    output logic                 push1,
    output par_codec_pkg::word_t push_data,
    output logic                 overflow
);
    import par_codec_pkg::*;

    // lane that receives the next accepted word
    lane_sel_e wr_lane;

    always_ff @(posedge clk) begin
        if (reset) begin
            push0   <= 1'b0;
            push1   <= 1'b0;
            wr_lane <= LANE_EVEN;
        end else if (in_valid) begin
            push0   <= (wr_lane == LANE_EVEN);
            push1   <= (wr_lane == LANE_ODD);
            wr_lane <= (wr_lane == LANE_EVEN) ? LANE_ODD : LANE_EVEN;
        end else begin
            push0   <= 1'b0;
            push1   <= 1'b0;
        end
    end

    // data register is shared, the push strobes pick the lane
    always_ff @(posedge clk) begin
        if (in_valid) begin
            push_data <= in_data;
        end
    end

    // sticky, set when a push lands on a full lane
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if ((push0 && full0) || (push1 && full1)) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/lane_merge.sv */
// reads the lanes in the dispatcher's order; out_credit must not exceed the credits spent
`default_nettype none
`timescale 1ns/1ps

`include "par_codec_consts.svh"

module lane_merge (
    input  logic                 clk,
    input  logic                 reset,
    input  par_codec_pkg::word_t rd_data0,
    input  par_codec_pkg::word_t rd_data1,
    input  logic                 not_empty0,
    input  logic                 not_empty1,
    input  logic                 out_credit,
    output logic                 pop0,
    output logic                 pop1,
    output logic                 out_valid,
    output par_codec_pkg::word_t out_data,
    output logic                 in_credit
);
    import par_codec_pkg::*;

    localparam int CREDIT_W = $clog2(`PC_OUT_CREDITS + 1);

    // lane holding the next word in input order
    lane_sel_e     rd_lane;
    logic [CREDIT_W-1:0] credits;

    logic          have_credit;
    logic          pop_any;
    word_t         pop_data;

    assign have_credit = (credits != '0);

    // only the current lane may be popped, so order is kept
    assign pop0 = (rd_lane == LANE_EVEN) && not_empty0 && have_credit;
    assign pop1 = (rd_lane == LANE_ODD) && not_empty1 && have_credit;

    assign pop_any  = pop0 || pop1;
    assign pop_data = (rd_lane == LANE_EVEN) ? rd_data0 : rd_data1;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_lane <= LANE_EVEN;
        end else if (pop_any) begin
            rd_lane <= (rd_lane == LANE_EVEN) ? LANE_ODD : LANE_EVEN;
        end
    end

    // output credits, spent per pop and returned by the receiver
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(`PC_OUT_CREDITS);
        end else begin
            case ({pop_any, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // word and upstream credit leave one cycle after the pop
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop_any;
            in_credit <= pop_any;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_any) begin
            out_data <= pop_data;
        end
    end

endmodule

`default_nettype wire

/* source/par_codec_consts.svh */
// sizing for both lanes and the credit pools; PC_PTR_W must equal $clog2(PC_DEPTH)
`ifndef PAR_CODEC_CONSTS_SVH
`define PAR_CODEC_CONSTS_SVH

// data word width in bits
`define PC_WIDTH 16

// entries per lane
// the upstream sender is granted twice this many credits
`define PC_DEPTH 8

// read and write pointer width for one lane
// the occupancy counter is one bit wider
`define PC_PTR_W 3

// output credits held by the merger after reset
`define PC_OUT_CREDITS 4

`endif

/* source/par_codec_pkg.sv */
// shared types; expects par_codec_consts.svh on the include path
`default_nettype none

`include "par_codec_consts.svh"

package par_codec_pkg;

    // lane that the next word is written to or read from
    typedef enum logic {
        LANE_EVEN = 1'b0,
        LANE_ODD  = 1'b1
    } lane_sel_e;

    // one data word on every RTL data port
    typedef logic [`PC_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

/* source/par_codec_top.sv */
// two-lane word buffer; the sender starts with 2*PC_DEPTH credits and must not exceed them
`default_nettype none
`timescale 1ns/1ps

module par_codec_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  par_codec_pkg::word_t in_data,
    output logic                 in_credit,
    output logic                 out_valid,
    output par_codec_pkg::word_t out_data,
    input  logic                 out_credit,
    output logic                 overflow
);
    import par_codec_pkg::*;

    // dispatcher to lanes
    logic  push0;
    logic  push1;
    word_t push_data;
    logic  full0;
    logic  full1;

    // lanes to merger
    word_t rd_data0;
    word_t rd_data1;
    logic  not_empty0;
    logic  not_empty1;
    logic  pop0;
    logic  pop1;

    lane_dispatch u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .full0     (full0),
        .full1     (full1),
        .push0     (push0),
        .push1     (push1),
        .push_data (push_data),
        .overflow  (overflow)
    );

    // even-numbered words
    lane_buffer u_lane0 (
        .clk       (clk),
        .reset     (reset),
        .push      (push0),
        .push_data (push_data),
        .pop       (pop0),
        .rd_data   (rd_data0),
        .not_empty (not_empty0),
        .full      (full0)
    );

    // odd-numbered words
    lane_buffer u_lane1 (
        .clk       (clk),
        .reset     (reset),
        .push      (push1),
        .push_data (push_data),
        .pop       (pop1),
        .rd_data   (rd_data1),
        .not_empty (not_empty1),
        .full      (full1)
    );

    lane_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .not_empty0 (not_empty0),
        .not_empty1 (not_empty1),
        .out_credit (out_credit),
        .pop0       (pop0),
        .pop1       (pop1),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire
